// ==== hw/conv_bram_ctrl_macros.svh ====
`ifndef CONV_BRAM_CTRL_MACROS_SVH
`define CONV_BRAM_CTRL_MACROS_SVH

////////////////////////////////////////
// Widths
////////////////////////////////////////

// Row and column counts
`define CBC_ADDR_W 10
// Pixel buffer word count
`define CBC_PFB_CNT_W 10
// Pixel sequence BRAM address
`define CBC_SEQ_ADDR_W 12
// Tap index within one window
`define CBC_TAP_W 4

////////////////////////////////////////
// Counts and latencies
////////////////////////////////////////

// 4 AWE times 2 CE each
`define CBC_NUM_CE 8
// One read per tap of a 3x3 window
`define CBC_WINDOW_CYCLES 9
// Sequence BRAM read latency in cycles
`define CBC_SEQ_RD_LATENCY 3
// Input rows loaded before the first output row
`define CBC_PRIME_ROWS 3

`endif

// ==== hw/conv_bram_ctrl_pkg.sv ====
`default_nettype none
`include "conv_bram_ctrl_macros.svh"

package conv_bram_ctrl_pkg;

    ////////////////////////////////////////
    // Job and read types
    ////////////////////////////////////////

    // Host job description
    typedef struct packed {
        logic [`CBC_ADDR_W-1:0] num_input_cols;
        logic [`CBC_ADDR_W-1:0] num_output_rows;
    } job_cfg_t;

    // Sequence BRAM read port
    typedef struct packed {
        logic                       rden;
        logic [`CBC_SEQ_ADDR_W-1:0] addr;
    } seq_rd_t;

    // Per-slot flags carried down the CE lanes
    typedef struct packed {
        logic                  execute;
        logic [`CBC_TAP_W-1:0] window_tap;
        logic                  row_end;
    } ce_flags_t;

    // Job phases
    typedef enum logic [2:0] {
        IDLE,
        PRIME,
        ACTIVE,
        REFILL,
        DRAIN,
        COMPLETE
    } seq_state_e;

endpackage

`default_nettype wire

// ==== hw/pixel_buffer_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "conv_bram_ctrl_macros.svh"

module pixel_buffer_fetch (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      words_wanted,
    input  logic [`CBC_PFB_CNT_W-1:0] pfb_full_count,
    input  logic                      fetch_ack,
    input  logic                      fetch_complete,
    output logic                      fetch_request,
    output logic                      fetch_in_progress,
    output logic                      pfb_rden
);

    // Words left in the pixel buffer
    logic [`CBC_PFB_CNT_W-1:0] pfb_count;
    logic                      words_wanted_r;
    // Request raised and not yet completed
    logic                      req_pending;
    logic                      buf_empty;
    logic                      start_fetch;

    assign buf_empty   = (pfb_count == '0);
    // Ask for more only when dry and nothing outstanding
    assign start_fetch = words_wanted && buf_empty && !fetch_in_progress && !req_pending;
    // At most one read per cycle
    assign pfb_rden    = words_wanted_r && !buf_empty;

    ////////////////////////////////////////
    // Fetch handshake
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_request     <= 1'b0;
            fetch_in_progress <= 1'b0;
            req_pending       <= 1'b0;
        end else begin
            // Request level drops after ack
            if (fetch_ack) begin
                fetch_request <= 1'b0;
            end else if (start_fetch) begin
                fetch_request <= 1'b1;
            end
            // Transfer window from ack to complete
            if (fetch_complete) begin
                fetch_in_progress <= 1'b0;
            end else if (fetch_ack) begin
                fetch_in_progress <= 1'b1;
            end
            if (fetch_complete) begin
                req_pending <= 1'b0;
            end else if (start_fetch) begin
                req_pending <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Buffer word count
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            pfb_count      <= '0;
            words_wanted_r <= 1'b0;
        end else begin
            words_wanted_r <= words_wanted;
            // Fresh load on completion, else one word per read
            if (fetch_complete && fetch_in_progress) begin
                pfb_count <= pfb_full_count;
            end else if (pfb_rden) begin
                pfb_count <= pfb_count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/window_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "conv_bram_ctrl_macros.svh"

module window_sequencer (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          job_start,
    input  conv_bram_ctrl_pkg::job_cfg_t  job_cfg,
    output logic                          job_accept,
    output logic                          job_complete,
    input  logic                          job_complete_ack,
    input  logic                          pipeline_flushed,
    output logic                          words_wanted,
    input  logic                          pfb_rden,
    output conv_bram_ctrl_pkg::seq_rd_t   seq_rd,
    output conv_bram_ctrl_pkg::ce_flags_t ce_head
);

    conv_bram_ctrl_pkg::seq_state_e state;
    // Job held from accept to completion
    conv_bram_ctrl_pkg::job_cfg_t   cfg;
    // Input position within a fill phase
    logic [`CBC_ADDR_W-1:0]         in_col;
    logic [`CBC_ADDR_W-1:0]         in_row;
    logic [`CBC_ADDR_W-1:0]         last_in_col;
    logic [`CBC_ADDR_W-1:0]         fill_last_row;
    logic                           filling;
    logic                           fill_done;
    // Output position during ACTIVE
    logic [`CBC_TAP_W-1:0]          tap;
    logic [`CBC_ADDR_W-1:0]         out_col;
    logic [`CBC_ADDR_W-1:0]         out_row;
    logic [`CBC_SEQ_ADDR_W-1:0]     seq_addr;
    logic                           active;
    logic                           window_last;
    logic                           row_last;
    logic                           job_last;
    // Flags of the read issued this cycle
    conv_bram_ctrl_pkg::ce_flags_t  rd_flags;
    conv_bram_ctrl_pkg::ce_flags_t  rd_pipe [`CBC_SEQ_RD_LATENCY];

    ////////////////////////////////////////
    // Phase decode
    ////////////////////////////////////////

    assign filling       = (state == conv_bram_ctrl_pkg::PRIME) ||
                           (state == conv_bram_ctrl_pkg::REFILL);
    assign active        = (state == conv_bram_ctrl_pkg::ACTIVE);
    assign last_in_col   = cfg.num_input_cols - 1'b1;
    // PRIME loads three rows, REFILL loads one
    assign fill_last_row = (state == conv_bram_ctrl_pkg::PRIME) ?
                           `CBC_ADDR_W'(`CBC_PRIME_ROWS - 1) : '0;
    assign fill_done     = filling && pfb_rden && (in_col == last_in_col) &&
                           (in_row == fill_last_row);
    // Dropped on the last read so the registered copy stops in time
    assign words_wanted  = filling && !fill_done;

    assign window_last   = (tap == `CBC_TAP_W'(`CBC_WINDOW_CYCLES - 1));
    // Output columns are input columns minus 2
    assign row_last      = window_last && (out_col == cfg.num_input_cols - 2'd3);
    assign job_last      = row_last && (out_row == cfg.num_output_rows - 1'b1);

    assign job_complete  = (state == conv_bram_ctrl_pkg::COMPLETE);

    // One read per cycle for the whole burst
    assign seq_rd.rden   = active;
    assign seq_rd.addr   = seq_addr;

    assign rd_flags.execute    = active;
    assign rd_flags.window_tap = tap;
    assign rd_flags.row_end    = active && row_last;

    ////////////////////////////////////////
    // Job FSM
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= conv_bram_ctrl_pkg::IDLE;
            job_accept <= 1'b0;
        end else begin
            job_accept <= 1'b0;
            case (state)
                conv_bram_ctrl_pkg::IDLE: begin
                    if (job_start) begin
                        job_accept <= 1'b1;
                        state      <= conv_bram_ctrl_pkg::PRIME;
                    end
                end
                conv_bram_ctrl_pkg::PRIME,
                conv_bram_ctrl_pkg::REFILL: begin
                    if (fill_done) begin
                        state <= conv_bram_ctrl_pkg::ACTIVE;
                    end
                end
                conv_bram_ctrl_pkg::ACTIVE: begin
                    // Burst always runs to the end of the row
                    if (job_last) begin
                        state <= conv_bram_ctrl_pkg::DRAIN;
                    end else if (row_last) begin
                        state <= conv_bram_ctrl_pkg::REFILL;
                    end
                end
                conv_bram_ctrl_pkg::DRAIN: begin
                    if (pipeline_flushed) begin
                        state <= conv_bram_ctrl_pkg::COMPLETE;
                    end
                end
                conv_bram_ctrl_pkg::COMPLETE: begin
                    if (job_complete_ack) begin
                        state <= conv_bram_ctrl_pkg::IDLE;
                    end
                end
                default: state <= conv_bram_ctrl_pkg::IDLE;
            endcase
        end
    end

    // Sampled on accept
    always_ff @(posedge clk) begin
        if ((state == conv_bram_ctrl_pkg::IDLE) && job_start) begin
            cfg <= job_cfg;
        end
    end

    ////////////////////////////////////////
    // Position counters
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            in_col <= '0;
            in_row <= '0;
        end else if (pfb_rden) begin
            if (in_col == last_in_col) begin
                in_col <= '0;
                in_row <= fill_done ? '0 : in_row + 1'b1;
            end else begin
                in_col <= in_col + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tap      <= '0;
            out_col  <= '0;
            out_row  <= '0;
            seq_addr <= '0;
        end else if (active) begin
            // Address restarts at 0 for every output row
            seq_addr <= row_last ? '0 : seq_addr + 1'b1;
            tap      <= window_last ? '0 : tap + 1'b1;
            if (row_last) begin
                out_col <= '0;
                out_row <= job_last ? '0 : out_row + 1'b1;
            end else if (window_last) begin
                out_col <= out_col + 1'b1;
            end
        end
    end

    // Flags follow their read through the BRAM latency
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `CBC_SEQ_RD_LATENCY; i++) begin
                rd_pipe[i] <= '0;
            end
        end else begin
            rd_pipe[0] <= rd_flags;
            for (int i = 1; i < `CBC_SEQ_RD_LATENCY; i++) begin
                rd_pipe[i] <= rd_pipe[i-1];
            end
        end
    end

    assign ce_head = rd_pipe[`CBC_SEQ_RD_LATENCY-1];

endmodule

`default_nettype wire

// ==== hw/ce_broadcast_chain.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "conv_bram_ctrl_macros.svh"

module ce_broadcast_chain (
    input  logic                                           clk,
    input  logic                                           rst,
    input  logic                                           job_accept,
    input  conv_bram_ctrl_pkg::ce_flags_t                  ce_head,
    output conv_bram_ctrl_pkg::ce_flags_t [`CBC_NUM_CE-1:0] ce_lanes,
    output logic [`CBC_ADDR_W-1:0]                         rows_retired
);

    // Last CE finished an output row
    logic row_leaving;

    assign row_leaving = ce_lanes[`CBC_NUM_CE-1].execute &&
                         ce_lanes[`CBC_NUM_CE-1].row_end;

    ////////////////////////////////////////
    // Lane shift
    ////////////////////////////////////////

    // One CE further each cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            ce_lanes <= '0;
        end else begin
            ce_lanes[0] <= ce_head;
            for (int k = 1; k < `CBC_NUM_CE; k++) begin
                ce_lanes[k] <= ce_lanes[k-1];
            end
        end
    end

    ////////////////////////////////////////
    // Retired rows
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            rows_retired <= '0;
        end else if (job_accept) begin
            // New job starts from zero
            rows_retired <= '0;
        end else if (row_leaving) begin
            rows_retired <= rows_retired + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== hw/conv_bram_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "conv_bram_ctrl_macros.svh"

module conv_bram_ctrl (
    input  logic                                           clk,
    input  logic                                           rst,
    // Job interface
    input  logic                                           job_start,
    input  conv_bram_ctrl_pkg::job_cfg_t                   job_cfg,
    output logic                                           job_accept,
    output logic                                           job_complete,
    input  logic                                           job_complete_ack,
    input  logic                                           pipeline_flushed,
    // Pixel fetcher
    output logic                                           fetch_request,
    input  logic                                           fetch_ack,
    output logic                                           fetch_in_progress,
    input  logic                                           fetch_complete,
    input  logic [`CBC_PFB_CNT_W-1:0]                      pfb_full_count,
    output logic                                           pfb_rden,
    // Sequence BRAM
    output conv_bram_ctrl_pkg::seq_rd_t                    seq_rd,
    // CE lanes
    output conv_bram_ctrl_pkg::ce_flags_t [`CBC_NUM_CE-1:0] ce_lanes,
    output logic [`CBC_ADDR_W-1:0]                         rows_retired
);

    logic                          words_wanted;
    conv_bram_ctrl_pkg::ce_flags_t ce_head;

    ////////////////////////////////////////
    // Input side
    ////////////////////////////////////////

    pixel_buffer_fetch pixel_buffer_fetch_i (
        .clk               (clk),
        .rst               (rst),
        .words_wanted      (words_wanted),
        .pfb_full_count    (pfb_full_count),
        .fetch_ack         (fetch_ack),
        .fetch_complete    (fetch_complete),
        .fetch_request     (fetch_request),
        .fetch_in_progress (fetch_in_progress),
        .pfb_rden          (pfb_rden)
    );

    // Job FSM and BRAM read addressing
    window_sequencer window_sequencer_i (
        .clk              (clk),
        .rst              (rst),
        .job_start        (job_start),
        .job_cfg          (job_cfg),
        .job_accept       (job_accept),
        .job_complete     (job_complete),
        .job_complete_ack (job_complete_ack),
        .pipeline_flushed (pipeline_flushed),
        .words_wanted     (words_wanted),
        .pfb_rden         (pfb_rden),
        .seq_rd           (seq_rd),
        .ce_head          (ce_head)
    );

    // Output side
    ce_broadcast_chain ce_broadcast_chain_i (
        .clk          (clk),
        .rst          (rst),
        .job_accept   (job_accept),
        .ce_head      (ce_head),
        .ce_lanes     (ce_lanes),
        .rows_retired (rows_retired)
    );

endmodule

`default_nettype wire

// ==== verification/tb_conv_bram_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "conv_bram_ctrl_macros.svh"

module tb_conv_bram_ctrl;

    localparam int TIMEOUT_CYCLES = 4000;

    logic                                            clk;
    logic                                            rst;
    logic                                            job_start;
    conv_bram_ctrl_pkg::job_cfg_t                    job_cfg;
    logic                                            job_accept;
    logic                                            job_complete;
    logic                                            job_complete_ack;
    logic                                            pipeline_flushed;
    logic                                            fetch_request;
    logic                                            fetch_ack;
    logic                                            fetch_in_progress;
    logic                                            fetch_complete;
    logic [`CBC_PFB_CNT_W-1:0]                       pfb_full_count;
    logic                                            pfb_rden;
    conv_bram_ctrl_pkg::seq_rd_t                     seq_rd;
    conv_bram_ctrl_pkg::ce_flags_t [`CBC_NUM_CE-1:0] ce_lanes;
    logic [`CBC_ADDR_W-1:0]                          rows_retired;

    int          mismatch_count;
    int          fail_count;
    logic [15:0] lfsr_state;
    bit          timed_out;
    // Observations of the last job
    int          accept_count;
    int          rden_count;
    int          fetch_count;
    int          read_count;
    int          row_end_count;

    conv_bram_ctrl conv_bram_ctrl_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////
    // Random delays
    ////////////////////////////////////////

    // Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic int rand_bits(input int n);
        int r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = (r << 1) | int'(lfsr_state[0]);
        end
        return r;
    endfunction

    ////////////////////////////////////////
    // Compare and report
    ////////////////////////////////////////

    task automatic check_flags(input string name, input conv_bram_ctrl_pkg::ce_flags_t got,
                               input conv_bram_ctrl_pkg::ce_flags_t exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_seq(input string name, input conv_bram_ctrl_pkg::seq_rd_t got,
                             input conv_bram_ctrl_pkg::seq_rd_t exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input logic [`CBC_ADDR_W-1:0] got,
                               input logic [`CBC_ADDR_W-1:0] exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    // Single control levels
    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic report_failure(input string msg);
        fail_count++;
        $display("ERROR %s", msg);
    endtask

    task automatic finish_run();
        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
        if (mismatch_count == 0 && fail_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (4) @(negedge clk);
        rst = 1'b0;
    endtask

    ////////////////////////////////////////
    // Job driver with fetcher model
    ////////////////////////////////////////

    // Starts a job at the current falling edge and runs it to acknowledged completion
    task automatic run_job(input int cols, input int rows, input int full);
        int                            cyc;
        int                            fphase;
        int                            fdelay;
        int                            flush_wait;
        int                            ack_wait;
        int                            model_cnt;
        int                            row_len;
        int                            exp_addr;
        int                            lane7_rows;
        bit                            done;
        bit                            in_burst;
        bit                            flushed_sent;
        bit                            complete_seen;
        bit                            ack_sent;
        bit                            exp_in_progress;
        conv_bram_ctrl_pkg::ce_flags_t hist [16];
        conv_bram_ctrl_pkg::ce_flags_t cur;
        conv_bram_ctrl_pkg::seq_rd_t   exp_rd;
        cyc = 0;
        fphase = 0;
        fdelay = 0;
        flush_wait = rand_bits(3);
        ack_wait = 0;
        model_cnt = 0;
        // Nine reads per output pixel
        row_len = (cols - 2) * `CBC_WINDOW_CYCLES;
        exp_addr = 0;
        lane7_rows = 0;
        done = 1'b0;
        in_burst = 1'b0;
        flushed_sent = 1'b0;
        complete_seen = 1'b0;
        ack_sent = 1'b0;
        exp_in_progress = 1'b0;
        accept_count = 0;
        rden_count = 0;
        fetch_count = 0;
        read_count = 0;
        row_end_count = 0;
        for (int i = 0; i < 16; i++) begin
            hist[i] = '0;
        end
        job_cfg.num_input_cols = `CBC_ADDR_W'(cols);
        job_cfg.num_output_rows = `CBC_ADDR_W'(rows);
        pfb_full_count = `CBC_PFB_CNT_W'(full);
        job_start = 1'b1;
        while (!done && cyc < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cyc++;
            job_start = 1'b0;
            fetch_ack = 1'b0;
            fetch_complete = 1'b0;
            job_complete_ack = 1'b0;
            // Accept exactly one cycle after start
            check_bit("job_accept", job_accept, cyc == 1);
            if (job_accept) begin
                accept_count++;
            end
            if (cyc == 2) begin
                check_count("rows_retired", rows_retired, '0);
            end
            if (pfb_rden) begin
                rden_count++;
                if (model_cnt == 0) begin
                    report_failure("pfb_rden strobe while the pixel buffer is empty");
                end
            end
            // Expected read address and flags
            cur = '0;
            if (seq_rd.rden) begin
                exp_rd.rden = 1'b1;
                exp_rd.addr = `CBC_SEQ_ADDR_W'(exp_addr);
                check_seq("seq_rd", seq_rd, exp_rd);
                cur.execute = 1'b1;
                cur.window_tap = `CBC_TAP_W'(exp_addr % `CBC_WINDOW_CYCLES);
                cur.row_end = (exp_addr == row_len - 1);
                read_count++;
                in_burst = !cur.row_end;
                exp_addr = cur.row_end ? 0 : exp_addr + 1;
            end else if (in_burst) begin
                report_failure("gap inside a sequence read burst");
                in_burst = 1'b0;
            end
            hist[cyc % 16] = cur;
            // Lane k trails the read by 4 + k cycles
            for (int k = 0; k < `CBC_NUM_CE; k++) begin
                check_flags($sformatf("ce_lanes[%0d]", k), ce_lanes[k],
                            hist[(cyc - 4 - k + 16) % 16]);
            end
            if (ce_lanes[0].execute && ce_lanes[0].row_end) begin
                row_end_count++;
            end
            if (ce_lanes[`CBC_NUM_CE-1].execute && ce_lanes[`CBC_NUM_CE-1].row_end) begin
                lane7_rows++;
            end
            // Transfer window runs from the cycle after ack to the cycle after complete
            check_bit("fetch_in_progress", fetch_in_progress, exp_in_progress);
            if (fphase != 0) begin
                // Request held until the ack, low after it
                check_bit("fetch_request", fetch_request, fphase == 1);
            end
            // Fetcher: request, ack after a delay, complete after another
            case (fphase)
                0: begin
                    if (fetch_request) begin
                        fdelay = rand_bits(2);
                        fphase = 1;
                    end
                end
                1: begin
                    if (fdelay == 0) begin
                        fetch_ack = 1'b1;
                        fetch_count++;
                        fdelay = rand_bits(2);
                        fphase = 2;
                    end else begin
                        fdelay--;
                    end
                end
                default: begin
                    if (fdelay == 0) begin
                        fetch_complete = 1'b1;
                        fphase = 0;
                    end else begin
                        fdelay--;
                    end
                end
            endcase
            if (fetch_ack) begin
                exp_in_progress = 1'b1;
            end
            // Buffer word count as the next edge will leave it
            if (fetch_complete) begin
                exp_in_progress = 1'b0;
                model_cnt = full;
            end else if (pfb_rden) begin
                model_cnt--;
            end
            // Flush some cycles after the last window leaves lane 7
            if (!flushed_sent && lane7_rows == rows) begin
                if (flush_wait == 0) begin
                    pipeline_flushed = 1'b1;
                    flushed_sent = 1'b1;
                end else begin
                    flush_wait--;
                end
            end
            if (job_complete && !flushed_sent) begin
                report_failure("job_complete rose before pipeline_flushed");
            end
            if (ack_sent) begin
                check_bit("job_complete", job_complete, 1'b0);
                pipeline_flushed = 1'b0;
                done = 1'b1;
            end else if (complete_seen) begin
                check_bit("job_complete", job_complete, 1'b1);
                if (ack_wait == 0) begin
                    job_complete_ack = 1'b1;
                    ack_sent = 1'b1;
                end else begin
                    ack_wait--;
                end
            end else if (job_complete) begin
                complete_seen = 1'b1;
                ack_wait = rand_bits(3);
            end
        end
        if (!done) begin
            report_failure("job did not complete within the cycle limit");
            timed_out = 1'b1;
        end
    endtask

    ////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////

    task automatic test_reset_and_start(input int cols, input int rows, input int full);
        apply_reset();
        repeat (2) begin
            check_bit("job_accept", job_accept, 1'b0);
            check_bit("job_complete", job_complete, 1'b0);
            check_bit("fetch_request", fetch_request, 1'b0);
            check_bit("fetch_in_progress", fetch_in_progress, 1'b0);
            check_bit("pfb_rden", pfb_rden, 1'b0);
            check_bit("seq_rd.rden", seq_rd.rden, 1'b0);
            for (int k = 0; k < `CBC_NUM_CE; k++) begin
                check_bit($sformatf("ce_lanes[%0d].execute", k), ce_lanes[k].execute, 1'b0);
            end
            @(negedge clk);
        end
        run_job(cols, rows, full);
        check_count("job_accept pulses", `CBC_ADDR_W'(accept_count), `CBC_ADDR_W'(1));
    endtask

    // Input rows are output rows plus 2
    task automatic test_buffer_traffic(input int cols, input int rows, input int full);
        int words;
        words = cols * (rows + 2);
        check_count("pfb_rden strobes", `CBC_ADDR_W'(rden_count), `CBC_ADDR_W'(words));
        check_count("fetches", `CBC_ADDR_W'(fetch_count), `CBC_ADDR_W'((words + full - 1) / full));
    endtask

    task automatic test_sequence_addressing(input int cols, input int rows);
        check_count("sequence reads", `CBC_ADDR_W'(read_count),
                    `CBC_ADDR_W'((cols - 2) * `CBC_WINDOW_CYCLES * rows));
    endtask

    task automatic test_execution_flags(input int rows);
        check_count("row_end on lane 0", `CBC_ADDR_W'(row_end_count), `CBC_ADDR_W'(rows));
    endtask

    task automatic test_completion(input int rows);
        check_bit("job_complete", job_complete, 1'b0);
        check_count("rows_retired", rows_retired, `CBC_ADDR_W'(rows));
    endtask

    task automatic test_second_job(input int cols, input int rows, input int full);
        run_job(cols, rows, full);
        check_count("job_accept pulses", `CBC_ADDR_W'(accept_count), `CBC_ADDR_W'(1));
        test_buffer_traffic(cols, rows, full);
        test_sequence_addressing(cols, rows);
        test_execution_flags(rows);
        test_completion(rows);
    endtask

    initial begin
        rst = 1'b1;
        job_start = 1'b0;
        job_cfg = '0;
        job_complete_ack = 1'b0;
        pipeline_flushed = 1'b0;
        fetch_ack = 1'b0;
        fetch_complete = 1'b0;
        pfb_full_count = '0;
        mismatch_count = 0;
        fail_count = 0;
        timed_out = 1'b0;
        lfsr_state = 16'd52;
        test_reset_and_start(6, 3, 10);
        if (!timed_out) begin
            test_buffer_traffic(6, 3, 10);
            test_sequence_addressing(6, 3);
            test_execution_flags(3);
            test_completion(3);
            test_second_job(8, 2, 8);
        end
        finish_run();
    end

endmodule

`default_nettype wire

// ==== conv_bram_ctrl.f ====
+incdir+hw
hw/conv_bram_ctrl_pkg.sv
hw/pixel_buffer_fetch.sv
hw/window_sequencer.sv
hw/ce_broadcast_chain.sv
hw/conv_bram_ctrl.sv
verification/tb_conv_bram_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the conv_bram_ctrl testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_conv_bram_ctrl \
    -f conv_bram_ctrl.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_conv_bram_ctrl)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "^TEST PASSED$"; then
    exit 0
fi
exit 1
